//--- hw/exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// ============================================================
// Execute stage widths and constants
// ============================================================

// Data and address width
`define EXU_XLEN 32

// RV32E has 16 architectural registers
`define EXU_RD_W 4

`define EXU_ECALL_CAUSE 32'd11  // Environment call from M-mode

// Trap vector base after reset
`define EXU_MTVEC_RESET 32'h8000_0000

`endif

//--- hw/exu_pkg.sv
`include "exu_settings.svh"

package exu_pkg;

  // ============================================================
  // ALU opcodes and stage payloads
  // ============================================================

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_SLE  = 4'd10,
    ALU_SLEU = 4'd11
  } alu_op_e;

  // One decoded instruction as handed over by decode
  typedef struct packed {
    logic [`EXU_XLEN-1:0] pc;
    logic [2:0]           funct3;
    logic [`EXU_XLEN-1:0] imm;
    logic [`EXU_XLEN-1:0] op1;
    logic [`EXU_XLEN-1:0] op2;
    logic [`EXU_XLEN-1:0] opj;      // Base for jump target and memory address
    alu_op_e              alu_op;
    logic [`EXU_RD_W-1:0] rd;
    logic                 ren;
    logic                 wen;
    logic                 jen;
    logic                 ben;
    logic                 system;
    logic                 csr_wen;
    logic                 ebreak;
    logic                 ecall;
    logic                 mret;
  } exu_issue_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0] wb_data;
    logic [`EXU_RD_W-1:0] rd;
    logic [`EXU_XLEN-1:0] npc;
    logic                 redirect;       // Fetch must restart at npc
    logic                 branch_retire;
    logic                 ebreak;
  } exu_result_t;

  typedef struct packed {
    logic                 ren;
    logic                 wen;
    logic [`EXU_XLEN-1:0] addr;
    logic [`EXU_XLEN-1:0] wdata;
    logic [2:0]           funct3;  // Access size and sign
  } mem_req_t;

endpackage

//--- hw/csr_pkg.sv
package csr_pkg;

  // ============================================================
  // Machine-mode CSR addresses and operations
  // ============================================================

  // Only the four registers kept by the stage
  typedef enum logic [11:0] {
    CSR_MSTATUS = 12'h300,
    CSR_MTVEC   = 12'h305,
    CSR_MEPC    = 12'h341,
    CSR_MCAUSE  = 12'h342
  } csr_addr_e;

  // Taken from funct3[1:0], so the immediate forms map onto
  // the same codes as the register forms
  typedef enum logic [1:0] {
    CSR_NONE  = 2'b00,
    CSR_WRITE = 2'b01,  // csrrw
    CSR_SET   = 2'b10,  // csrrs
    CSR_CLEAR = 2'b11   // csrrc
  } csr_op_e;

endpackage

//--- hw/exu_ctrl.sv
`timescale 1ns/100ps
`include "exu_settings.svh"

module exu_ctrl import exu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  // Decode side
  input  logic                 valid_i,
  input  exu_issue_t           issue_i,
  output logic                 ready_o,
  // Writeback side
  output logic                 valid_o,
  output exu_result_t          result_o,
  input  logic                 next_ready_i,
  // Load/store unit
  output logic                 mem_req_o,
  output mem_req_t             mem_o,
  input  logic                 mem_rvalid_i,
  input  logic [`EXU_XLEN-1:0] mem_rdata_i,
  input  logic                 mem_wready_i,
  // Datapath modules
  input  logic [`EXU_XLEN-1:0] alu_res_i,
  input  logic [`EXU_XLEN-1:0] csr_rdata_i,
  input  logic [`EXU_XLEN-1:0] npc_i,
  input  logic                 redirect_i,
  output exu_issue_t           iss_o,
  output logic                 csr_commit_o
);

  typedef enum logic [1:0] {
    IDLE,
    MEM_WAIT,
    DONE
  } state_e;

  state_e               state_q;
  state_e               state_d;
  exu_issue_t           iss_q;
  logic [`EXU_XLEN-1:0] load_q;
  logic [`EXU_XLEN-1:0] wb_sel;
  logic                 accept;
  logic                 mem_done;

  // ============================================================
  // Handshake and sequencing
  // ============================================================

  assign ready_o = (state_q != MEM_WAIT) && next_ready_i;
  assign accept  = valid_i && ready_o;

  // Completion strobe matching the outstanding access
  assign mem_done = (iss_q.ren && mem_rvalid_i) || (iss_q.wen && mem_wready_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      MEM_WAIT: begin
        if (mem_done) begin
          state_d = DONE;
        end
      end
      DONE: begin
        if (next_ready_i) begin
          state_d = IDLE;  // Result taken, nothing new behind it
        end
      end
      default: begin
        state_d = state_q;
      end
    endcase
    // A new instruction replaces the result taken on the same edge
    if (accept) begin
      state_d = (issue_i.ren || issue_i.wen) ? MEM_WAIT : DONE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      iss_q <= issue_i;
    end
    if (state_q == MEM_WAIT && iss_q.ren && mem_rvalid_i) begin
      load_q <= mem_rdata_i;
    end
  end

  assign valid_o   = (state_q == DONE);
  assign mem_req_o = (state_q == MEM_WAIT);

  // CSR side effects land when writeback takes the result
  assign csr_commit_o = valid_o && next_ready_i && iss_q.system;

  assign iss_o = iss_q;

  // ============================================================
  // Memory request and result
  // ============================================================

  assign mem_o.ren    = iss_q.ren;
  assign mem_o.wen    = iss_q.wen;
  assign mem_o.addr   = iss_q.opj + iss_q.imm;
  assign mem_o.wdata  = iss_q.op2;
  assign mem_o.funct3 = iss_q.funct3;

  always_comb begin
    if (iss_q.rd == '0) begin
      wb_sel = '0;  // x0 is never written
    end else if (iss_q.ren) begin
      wb_sel = load_q;
    end else if (iss_q.system) begin
      wb_sel = csr_rdata_i;  // Old CSR value
    end else begin
      wb_sel = alu_res_i;
    end
  end

  assign result_o.wb_data       = wb_sel;
  assign result_o.rd            = iss_q.rd;
  assign result_o.npc           = npc_i;
  assign result_o.redirect      = redirect_i;
  assign result_o.branch_retire = iss_q.system || iss_q.ben || iss_q.ren;
  assign result_o.ebreak        = iss_q.ebreak;

endmodule

//--- hw/exu_alu.sv
`timescale 1ns/100ps
`include "exu_settings.svh"

module exu_alu import exu_pkg::*; (
  input  alu_op_e              op_i,
  input  logic [`EXU_XLEN-1:0] src1_i,
  input  logic [`EXU_XLEN-1:0] src2_i,
  output logic [`EXU_XLEN-1:0] res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  // RV32 shifts use only the low five bits
  assign shamt = src2_i[4:0];

  assign lt_s = $signed(src1_i) < $signed(src2_i);
  assign lt_u = src1_i < src2_i;
  assign eq   = (src1_i == src2_i);

  always_comb begin
    case (op_i)
      ALU_ADD:  res_o = src1_i + src2_i;
      ALU_SUB:  res_o = src1_i - src2_i;  // Zero result means equal
      ALU_SLL:  res_o = src1_i << shamt;
      ALU_SRL:  res_o = src1_i >> shamt;
      ALU_SRA:  res_o = $unsigned($signed(src1_i) >>> shamt);
      ALU_XOR:  res_o = src1_i ^ src2_i;
      ALU_OR:   res_o = src1_i | src2_i;
      ALU_AND:  res_o = src1_i & src2_i;
      ALU_SLT: begin
        res_o = {{(`EXU_XLEN-1){1'b0}}, lt_s};
      end
      ALU_SLTU: begin
        res_o = {{(`EXU_XLEN-1){1'b0}}, lt_u};
      end
      // Less-or-equal forms serve bge/bgeu with swapped operands
      ALU_SLE: begin
        res_o = {{(`EXU_XLEN-1){1'b0}}, lt_s | eq};
      end
      ALU_SLEU: begin
        res_o = {{(`EXU_XLEN-1){1'b0}}, lt_u | eq};
      end
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule

//--- hw/exu_csr.sv
`timescale 1ns/100ps
`include "exu_settings.svh"

module exu_csr import exu_pkg::*, csr_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 commit_i,
  input  exu_issue_t           iss_i,
  output logic [`EXU_XLEN-1:0] rdata_o,
  output logic [`EXU_XLEN-1:0] mepc_o,
  output logic [`EXU_XLEN-1:0] mtvec_o
);

  csr_addr_e            addr;
  csr_op_e              op;
  logic [`EXU_XLEN-1:0] wdata;
  logic [`EXU_XLEN-1:0] mstatus_q;
  logic [`EXU_XLEN-1:0] mtvec_q;
  logic [`EXU_XLEN-1:0] mepc_q;
  logic [`EXU_XLEN-1:0] mcause_q;

  // The CSR number sits in the low twelve bits of the immediate
  assign addr = csr_addr_e'(iss_i.imm[11:0]);
  assign op   = csr_op_e'(iss_i.funct3[1:0]);

  always_comb begin
    case (addr)
      CSR_MSTATUS: rdata_o = mstatus_q;
      CSR_MTVEC:   rdata_o = mtvec_q;
      CSR_MEPC:    rdata_o = mepc_q;
      CSR_MCAUSE:  rdata_o = mcause_q;
      default:     rdata_o = '0;
    endcase
  end

  // ============================================================
  // Read-modify-write value
  // ============================================================

  always_comb begin
    case (op)
      CSR_WRITE: wdata = iss_i.op1;
      CSR_SET:   wdata = rdata_o | iss_i.op1;
      CSR_CLEAR: wdata = rdata_o & ~iss_i.op1;
      default:   wdata = rdata_o;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= `EXU_MTVEC_RESET;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (commit_i) begin
      if (iss_i.csr_wen && op != CSR_NONE) begin
        case (addr)
          CSR_MSTATUS: mstatus_q <= wdata;
          CSR_MTVEC:   mtvec_q   <= wdata;
          CSR_MEPC:    mepc_q    <= wdata;
          CSR_MCAUSE:  mcause_q  <= wdata;
          default:     mstatus_q <= mstatus_q;  // Unknown CSR ignores the write
        endcase
      end
      // Trap entry
      if (iss_i.ecall) begin
        mepc_q   <= iss_i.pc;
        mcause_q <= `EXU_ECALL_CAUSE;
      end
    end
  end

  assign mepc_o  = mepc_q;
  assign mtvec_o = mtvec_q;

endmodule

//--- hw/exu_branch.sv
`timescale 1ns/100ps
`include "exu_settings.svh"

module exu_branch import exu_pkg::*; (
  input  exu_issue_t           iss_i,
  input  logic [`EXU_XLEN-1:0] alu_res_i,
  input  logic [`EXU_XLEN-1:0] mepc_i,
  input  logic [`EXU_XLEN-1:0] mtvec_i,
  output logic [`EXU_XLEN-1:0] npc_o,
  output logic                 redirect_o
);

  logic [`EXU_XLEN-1:0] target;
  logic                 taken;

  assign target = iss_i.opj + iss_i.imm;

  // Decode picks the opcode so that one zero test covers each condition
  always_comb begin
    case (iss_i.alu_op)
      ALU_SUB: begin
        taken = ~|alu_res_i;  // beq
      end
      ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SLE, ALU_SLEU: begin
        taken = |alu_res_i;
      end
      default: begin
        taken = 1'b0;
      end
    endcase
  end

  assign redirect_o = iss_i.ben ? taken : (iss_i.jen || iss_i.ecall || iss_i.mret);

  always_comb begin
    if (iss_i.ecall) begin
      npc_o = mtvec_i;
    end else if (iss_i.mret) begin
      npc_o = mepc_i;
    end else begin
      npc_o = target;
    end
  end

endmodule

//--- hw/exu_top.sv
`timescale 1ns/100ps
`include "exu_settings.svh"

module exu_top import exu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  // Decode side
  input  logic                 valid_i,
  input  exu_issue_t           issue_i,
  output logic                 ready_o,
  // Writeback side
  output logic                 valid_o,
  output exu_result_t          result_o,
  input  logic                 next_ready_i,
  // Load/store unit
  output logic                 mem_req_o,
  output mem_req_t             mem_o,
  input  logic                 mem_rvalid_i,
  input  logic [`EXU_XLEN-1:0] mem_rdata_i,
  input  logic                 mem_wready_i
);

  exu_issue_t           iss;
  logic [`EXU_XLEN-1:0] alu_res;
  logic [`EXU_XLEN-1:0] csr_rdata;
  logic [`EXU_XLEN-1:0] mepc;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] npc;
  logic                 redirect;
  logic                 csr_commit;

  exu_ctrl ctrl0 (
    .clk          (clk),
    .rst          (rst),
    .valid_i      (valid_i),
    .issue_i      (issue_i),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .result_o     (result_o),
    .next_ready_i (next_ready_i),
    .mem_req_o    (mem_req_o),
    .mem_o        (mem_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_wready_i (mem_wready_i),
    .alu_res_i    (alu_res),
    .csr_rdata_i  (csr_rdata),
    .npc_i        (npc),
    .redirect_i   (redirect),
    .iss_o        (iss),
    .csr_commit_o (csr_commit)
  );

  exu_alu alu0 (
    .op_i   (iss.alu_op),
    .src1_i (iss.op1),
    .src2_i (iss.op2),
    .res_o  (alu_res)
  );

  exu_csr csr0 (
    .clk      (clk),
    .rst      (rst),
    .commit_i (csr_commit),
    .iss_i    (iss),
    .rdata_o  (csr_rdata),
    .mepc_o   (mepc),
    .mtvec_o  (mtvec)
  );

  exu_branch branch0 (
    .iss_i      (iss),
    .alu_res_i  (alu_res),
    .mepc_i     (mepc),
    .mtvec_i    (mtvec),
    .npc_o      (npc),
    .redirect_o (redirect)
  );

endmodule

//--- dv/tb_exu.sv
`timescale 1ns/100ps
`include "exu_settings.svh"

module tb_exu import exu_pkg::*; ();

  localparam int MAX_REC = 64;

  logic                 clk;
  logic                 rst;
  logic                 valid_i;
  exu_issue_t           issue_i;
  logic                 ready_o;
  logic                 valid_o;
  exu_result_t          result_o;
  logic                 next_ready_i;
  logic                 mem_req_o;
  mem_req_t             mem_o;
  logic                 mem_rvalid_i;
  logic [`EXU_XLEN-1:0] mem_rdata_i;
  logic                 mem_wready_i;

  exu_issue_t           rec_issue [MAX_REC];
  exu_result_t          rec_exp [MAX_REC];
  logic [`EXU_XLEN-1:0] rec_addr [MAX_REC];
  logic [`EXU_XLEN-1:0] rec_ldata [MAX_REC];
  int                   rec_lat [MAX_REC];
  int                   n_rec;
  int                   received;
  int                   cycles;
  int                   limit;
  int                   mem_idx_q [$];  // Records with a memory access still to answer
  logic [31:0]          lfsr;
  logic                 stalled;
  exu_result_t          held;
  logic                 in_stage;   // An instruction sits in the stage
  logic                 mem_busy;   // Its load or store is still outstanding
  logic                 exp_ready;

  exu_top dut0 (.*);

  always #20 clk = ~clk;

  // ============================================================
  // Helpers
  // ============================================================

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    abort_run($sformatf("[FAIL] at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_strobe(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_result(input exu_result_t got, input exu_result_t exp);
    if (got.wb_data !== exp.wb_data)
      report_mismatch("result_o.wb_data", got.wb_data, exp.wb_data);
    if (got.rd !== exp.rd)
      report_mismatch("result_o.rd", 32'(got.rd), 32'(exp.rd));
    if (got.npc !== exp.npc)
      report_mismatch("result_o.npc", got.npc, exp.npc);
    if (got.redirect !== exp.redirect)
      report_mismatch("result_o.redirect", 32'(got.redirect), 32'(exp.redirect));
    if (got.branch_retire !== exp.branch_retire)
      report_mismatch("result_o.branch_retire", 32'(got.branch_retire),
                      32'(exp.branch_retire));
    if (got.ebreak !== exp.ebreak)
      report_mismatch("result_o.ebreak", 32'(got.ebreak), 32'(exp.ebreak));
  endtask

  task automatic check_mem(input mem_req_t got, input mem_req_t exp);
    if (got.ren !== exp.ren)
      report_mismatch("mem_o.ren", 32'(got.ren), 32'(exp.ren));
    if (got.wen !== exp.wen)
      report_mismatch("mem_o.wen", 32'(got.wen), 32'(exp.wen));
    if (got.addr !== exp.addr)
      report_mismatch("mem_o.addr", got.addr, exp.addr);
    if (got.wdata !== exp.wdata)
      report_mismatch("mem_o.wdata", got.wdata, exp.wdata);
    if (got.funct3 !== exp.funct3)
      report_mismatch("mem_o.funct3", 32'(got.funct3), 32'(exp.funct3));
  endtask

  task automatic read_records();
    int          fd;
    int          cnt;
    int          lat;
    string       line;
    logic [31:0] pc, imm, op1, op2, opj, ldata, wb, npc, addr;
    logic [3:0]  alu, rd, xrd;
    logic [2:0]  f3, xflags;
    logic [8:0]  flags;
    fd = $fopen("dv/exu_stimulus.txt", "r");
    if (fd == 0)
      abort_run("Cannot open the stimulus file dv/exu_stimulus.txt");
    n_rec = 0;
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %b %d %h %h %h %h %b %h",
                    pc, f3, imm, op1, op2, opj, alu, rd, flags, lat, ldata,
                    wb, xrd, npc, xflags, addr);
      if (cnt != 16 || n_rec == MAX_REC)
        abort_run($sformatf("Bad or surplus stimulus line: %s", line));
      // File columns follow the struct field order
      rec_issue[n_rec] = {pc, f3, imm, op1, op2, opj, alu, rd, flags};
      rec_exp[n_rec]   = {wb, xrd, npc, xflags};
      rec_addr[n_rec]  = addr;
      rec_ldata[n_rec] = ldata;
      rec_lat[n_rec]   = lat;
      n_rec++;
    end
    $fclose(fd);
  endtask

  // ============================================================
  // Decode side and back-pressure
  // ============================================================

  initial begin : main
    logic [31:0] bits;
    int          idle;
    int          issued;
    clk          = 1'b0;
    rst          = 1'b1;
    valid_i      = 1'b0;
    issue_i      = '0;
    next_ready_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    mem_wready_i = 1'b0;
    lfsr         = 32'h6d13;
    received     = 0;
    cycles       = 0;
    stalled      = 1'b0;
    in_stage     = 1'b0;
    mem_busy     = 1'b0;
    read_records();
    limit = n_rec * 40 + 100;
    repeat (3) @(posedge clk);
    #2;
    rst    = 1'b0;
    issued = 0;
    draw_bits(2, bits);
    idle = int'(bits);
    while (received < n_rec) begin
      @(posedge clk);
      if (valid_i && ready_o) begin
        if (issue_i.ren || issue_i.wen)
          mem_idx_q.push_back(issued);
        issued++;
        draw_bits(2, bits);
        idle = int'(bits);
      end
      #2;
      draw_bits(1, bits);
      next_ready_i = bits[0];
      if (issued < n_rec && idle == 0) begin
        valid_i = 1'b1;
        issue_i = rec_issue[issued];  // Held until accepted
      end else begin
        valid_i = 1'b0;
        if (idle > 0)
          idle--;
      end
    end
    next_ready_i = 1'b1;
    repeat (4) @(posedge clk);
    if (valid_o || mem_req_o) begin
      abort_run("Stage still busy after the last record was delivered");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

  // ============================================================
  // Load/store responder, writeback side and timeout
  // ============================================================

  initial begin : responder
    int       idx;
    mem_req_t exp_mem;
    forever begin
      @(posedge clk);
      if (!rst && mem_req_o) begin
        if (mem_idx_q.size() == 0)
          abort_run("Memory request seen with no load or store issued");
        idx     = mem_idx_q.pop_front();
        exp_mem = {rec_issue[idx].ren, rec_issue[idx].wen, rec_addr[idx],
                   rec_issue[idx].op2, rec_issue[idx].funct3};
        check_mem(mem_o, exp_mem);
        repeat (rec_lat[idx]) begin
          @(posedge clk);
          if (!mem_req_o)
            abort_run("mem_req_o dropped before the response pulse");
        end
        #2;
        mem_rvalid_i = rec_issue[idx].ren;
        mem_wready_i = rec_issue[idx].wen;
        mem_rdata_i  = rec_ldata[idx];
        @(posedge clk);
        #2;
        mem_rvalid_i = 1'b0;
        mem_wready_i = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      // Strobes expected from the occupancy seen before this edge
      exp_ready = next_ready_i && !mem_busy;
      check_strobe("ready_o", ready_o, exp_ready);
      check_strobe("valid_o", valid_o, in_stage && !mem_busy);
      check_strobe("mem_req_o", mem_req_o, mem_busy);
      if (stalled && (!valid_o || result_o !== held))
        abort_run("Result changed while writeback was stalling");
      if (valid_o && next_ready_i) begin
        if (received >= n_rec)
          abort_run("Result delivered beyond the last record");
        check_result(result_o, rec_exp[received]);
        received++;
        in_stage = 1'b0;
      end
      // The completion strobe ends the outstanding access
      if (mem_busy && (mem_rvalid_i || mem_wready_i))
        mem_busy = 1'b0;
      if (valid_i && exp_ready) begin
        in_stage = 1'b1;
        mem_busy = issue_i.ren || issue_i.wen;
      end
      stalled = valid_o && !next_ready_i;
      held    = result_o;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit)
      abort_run($sformatf("Timeout after %0d cycles with %0d of %0d results",
                          cycles, received, n_rec));
  end

endmodule

//--- dv/exu_stimulus.txt
# pc f3 imm op1 op2 opj alu rd flags(ren wen jen ben sys csr_wen ebreak ecall mret) lat ldata
# then expected: wb_data rd npc flags(redirect branch_retire ebreak) mem_addr
100 0 0 5 7 0 0 1 000000000 0 0  c 1 0 000 0
104 0 0 5 7 0 1 2 000000000 0 0  fffffffe 2 0 000 0
108 0 0 3 24 0 2 3 000000000 0 0  30 3 0 000 0
10c 0 0 fffffff0 1 0 3 4 000000000 0 0  1 4 0 000 0
110 0 0 fffffff0 1 0 4 5 000000000 0 0  0 5 0 000 0
114 0 0 ff00ff00 0ff00ff0 0 5 6 000000000 0 0  f0f0f0f0 6 0 000 0
118 0 0 80000000 4 0 6 7 000000000 0 0  08000000 7 0 000 0
11c 0 0 80000000 4 0 7 8 000000000 0 0  f8000000 8 0 000 0
120 0 0 f0 f 0 8 9 000000000 0 0  ff 9 0 000 0
124 0 0 f0 3c 0 9 a 000000000 0 0  30 a 0 000 0
128 0 0 ffffffff ffffffff 0 a b 000000000 0 0  1 b 0 000 0
12c 0 0 ffffffff 1 0 b c 000000000 0 0  0 c 0 000 0
130 0 0 5 7 0 0 0 000000000 0 0  0 0 0 000 0
200 0 20 9 9 200 1 0 000100000 0 0  0 0 220 110 0
204 1 20 9 8 200 1 0 000100000 0 0  0 0 220 010 0
208 1 20 9 8 200 5 0 000100000 0 0  0 0 220 110 0
20c 0 20 9 9 200 5 0 000100000 0 0  0 0 220 010 0
210 4 20 ffffffff 0 200 3 0 000100000 0 0  0 0 220 110 0
214 6 20 ffffffff 0 200 4 0 000100000 0 0  0 0 220 010 0
218 5 20 3 3 200 a 0 000100000 0 0  0 0 220 110 0
21c 7 20 4 3 200 b 0 000100000 0 0  0 0 220 010 0
220 0 20 0 0 200 0 0 000100000 0 0  0 0 220 010 0
300 0 40 300 4 300 0 1 001000000 0 0  304 1 340 100 0
400 2 8 0 0 1000 0 5 100000000 3 deadbeef  deadbeef 5 1008 010 1008
404 2 c 0 cafef00d 1000 0 0 010000000 5 0  0 0 100c 000 100c
408 4 fffffffc 0 0 2000 0 6 100000000 0 80  80 6 1ffc 010 1ffc
500 1 300 f0 0 0 0 1 000011000 0 0  0 1 300 010 0
504 2 300 f0f 0 0 0 2 000011000 0 0  f0 2 300 010 0
508 3 300 f 0 0 0 3 000011000 0 0  fff 3 300 010 0
50c 2 300 0 0 0 0 4 000010000 0 0  ff0 4 300 010 0
510 1 305 800 0 0 0 5 000011000 0 0  80000000 5 305 010 0
600 0 0 0 0 0 0 0 000010010 0 0  0 0 800 110 0
604 2 342 0 0 0 0 6 000010000 0 0  b 6 342 010 0
608 2 341 0 0 0 0 7 000010000 0 0  600 7 341 010 0
800 0 0 0 0 0 0 0 000010001 0 0  0 0 600 110 0
60c 0 0 0 0 0 0 0 000010100 0 0  0 0 0 011 0
610 1 7c0 ffff 0 0 0 8 000011000 0 0  0 8 7c0 010 0
614 2 300 0 0 0 0 9 000010000 0 0  ff0 9 300 010 0

//--- tb.f
+incdir+hw
hw/exu_pkg.sv
hw/csr_pkg.sv
hw/exu_ctrl.sv
hw/exu_alu.sv
hw/exu_csr.sv
hw/exu_branch.sv
hw/exu_top.sv
dv/tb_exu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_exu
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^Test passed$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
